// File: freelist.f
freelist_pkg.sv
prf_fifo.sv
freelist_ckpt_bank.sv
freelist_bank_ctrl.sv
freelist_csr.sv
freelist_top.sv
tb_freelist_chk.sv
tb_freelist.sv

// File: run.sh
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_freelist -f freelist.f -o sim_freelist \
    && ./obj_dir/sim_freelist > sim.log 2>&1 \
    && ! grep -q "TEST RESULT: FAIL" sim.log \
    && grep -q "TEST RESULT: PASS" sim.log \
    && { cat sim.log; echo "Simulation passed"; } \
    || { cat sim.log 2>/dev/null; echo "Simulation failed"; exit 1; }

// File: tb_freelist.sv
// Table-driven testbench for the free-list stage; run through freelist.f and run.sh
`timescale 1ns/1ns

module tb_freelist;

    localparam int OP_OPEN    = 0;
    localparam int OP_PUSH    = 1;
    localparam int OP_COMMIT  = 2;
    localparam int OP_ABANDON = 3;
    localparam int OP_WRITE   = 4;
    localparam int OP_READ    = 5;
    localparam int OP_DRAIN   = 6;
    localparam int OP_STALL   = 7;
    localparam int OP_OPENRDY = 8;
    localparam int OP_WAIT    = 9;
    localparam int OP_RDREL   = 10;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic open_en = 1'b0;
    logic push_en = 1'b0;
    logic commit_en = 1'b0;
    logic abandon_en = 1'b0;
    freelist_pkg::fgr_t open_fgr = '0;
    freelist_pkg::fgr_t push_fgr = '0;
    freelist_pkg::fgr_t commit_fgr = '0;
    freelist_pkg::fgr_t abandon_fgr = '0;
    freelist_pkg::prf_t push_prf = '0;
    freelist_pkg::prf_t release_prf;
    logic release_ready = 1'b1;
    logic release_valid;
    logic open_ready;
    logic push_ready;
    freelist_pkg::csr_addr_t awaddr = '0;
    freelist_pkg::csr_addr_t araddr = '0;
    logic awvalid = 1'b0;
    logic wvalid = 1'b0;
    logic bready = 1'b1;
    logic arvalid = 1'b0;
    logic rready = 1'b1;
    logic [31:0] wdata = '0;
    logic [31:0] rdata;
    logic [3:0] wstrb = 4'hf;
    logic awready;
    logic wready;
    logic bvalid;
    logic arready;
    logic rvalid;
    logic [1:0] bresp;
    logic [1:0] rresp;

    // Stimulus table, one column per queue
    int op_q[$];
    logic [2:0] fgr_q[$];
    logic [31:0] val_q[$];
    logic [31:0] exp_q[$];
    string name_q[$];

    // Pending {fgr, prf} entries and the expected release order
    logic [8:0] pend[$];
    logic [5:0] exp_rel[$];
    int rel_total = 0;
    int errors = 0;
    int tests = 0;
    int failed_tests = 0;
    int seed = 32'hbfaa;
    logic stall_mode = 1'b0;
    logic table_ready = 1'b0;
    string cur_name = "reset";

    freelist_top dut (.*);

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp, act);
            errors++;
        end
    endtask

    function automatic void add_step(input int op, input int fgr, input int val, input int exp,
                                     input string name);
        op_q.push_back(op);
        fgr_q.push_back(3'(fgr));
        val_q.push_back(32'(val));
        exp_q.push_back(32'(exp));
        name_q.push_back(name);
    endfunction

    // Random stall of the release port
    always @(negedge clk) begin
        int rnd;
        rnd = $random(seed);
        release_ready = stall_mode ? rnd[0] : 1'b1;
    end

    always @(posedge clk) begin
        if (rst_n && release_valid && release_ready) begin
            if (exp_rel.size() == 0) begin
                $display("%s: PRF %0d was released but none was expected", cur_name, release_prf);
                errors++;
            end else begin
                check(cur_name, 32'(exp_rel.pop_front()), 32'(release_prf));
            end
        end
    end

    // Moves or drops the model entries of one group
    task automatic model_take(input logic [2:0] fgr, input logic to_release);
        logic [8:0] rest[$];
        foreach (pend[k]) begin
            if (pend[k][8:6] == fgr) begin
                if (to_release) begin
                    exp_rel.push_back(pend[k][5:0]);
                    rel_total++;
                end
            end else begin
                rest.push_back(pend[k]);
            end
        end
        pend = rest;
    endtask

    task automatic axi_write(input string name, input logic [31:0] addr, input logic [31:0] data);
        int n;
        @(negedge clk);
        awaddr = addr[3:0];
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        bready = 1'b0;
        check(name, 32'h1, 32'(awready && wready));
        @(negedge clk);
        awvalid = 1'b0;
        wvalid = 1'b0;
        n = 0;
        while (!bvalid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!bvalid) begin
            $display("%s: no write response arrived", name);
            errors++;
        end
        // Response has to wait for bready
        @(negedge clk);
        check(name, 32'h1, 32'(bvalid));
        check(name, 32'h0, 32'(bresp));
        bready = 1'b1;
        @(negedge clk);
        check(name, 32'h0, 32'(bvalid));
    endtask

    task automatic axi_read(input string name, input logic [31:0] addr, input logic [31:0] exp);
        @(negedge clk);
        araddr = addr[3:0];
        arvalid = 1'b1;
        check(name, 32'h1, 32'(arready));
        @(negedge clk);
        arvalid = 1'b0;
        if (!rvalid) begin
            $display("%s: read data did not arrive", name);
            errors++;
        end
        check(name, exp, rdata);
        check(name, 32'h0, 32'(rresp));
    endtask

    task automatic drain(input string name);
        int n;
        n = 0;
        while ((exp_rel.size() != 0 || release_valid) && n < 300) begin
            @(negedge clk);
            n++;
        end
        if (exp_rel.size() != 0) begin
            $display("%s: %0d PRFs were never released", name, exp_rel.size());
            errors++;
        end
        // Bank retires one edge after its last pop
        repeat (2) @(negedge clk);
    endtask

    task automatic run_step(input int i);
        string nm;
        logic [31:0] v;
        nm = name_q[i];
        v = val_q[i];
        case (op_q[i])
            OP_OPEN: begin
                @(negedge clk);
                open_fgr = fgr_q[i];
                open_en = 1'b1;
                @(negedge clk);
                open_en = 1'b0;
            end
            OP_PUSH: begin
                @(negedge clk);
                push_fgr = fgr_q[i];
                push_prf = v[5:0];
                push_en = 1'b1;
                #1;
                check(nm, exp_q[i], 32'(push_ready));
                if (exp_q[i] == 32'h1) begin
                    pend.push_back({fgr_q[i], v[5:0]});
                end
                @(negedge clk);
                push_en = 1'b0;
            end
            OP_COMMIT, OP_ABANDON: begin
                @(negedge clk);
                model_take(fgr_q[i], op_q[i] == OP_COMMIT);
                commit_fgr = fgr_q[i];
                abandon_fgr = fgr_q[i];
                commit_en = (op_q[i] == OP_COMMIT);
                abandon_en = (op_q[i] == OP_ABANDON);
                @(negedge clk);
                commit_en = 1'b0;
                abandon_en = 1'b0;
            end
            OP_WRITE: axi_write(nm, v, exp_q[i]);
            OP_READ: axi_read(nm, v, exp_q[i]);
            OP_RDREL: axi_read(nm, v, 32'(rel_total));
            OP_DRAIN: drain(nm);
            OP_STALL: stall_mode = v[0];
            OP_OPENRDY: check(nm, exp_q[i], 32'(open_ready));
            default: repeat (v) @(negedge clk);
        endcase
    endtask

    initial begin
        add_step(OP_OPEN, 1, 0, 0, "commit_order");
        add_step(OP_OPEN, 2, 0, 0, "commit_order");
        for (int k = 0; k < 3; k++) add_step(OP_PUSH, 1, 10 + k, 1, "commit_order");
        for (int k = 0; k < 3; k++) add_step(OP_PUSH, 2, 20 + k, 1, "commit_order");
        add_step(OP_COMMIT, 1, 0, 0, "commit_order");
        add_step(OP_DRAIN, 0, 0, 0, "commit_order");
        add_step(OP_READ, 0, 'h0, 'h02, "commit_order");
        add_step(OP_OPEN, 3, 0, 0, "full_bank");
        for (int k = 0; k < 4; k++) add_step(OP_PUSH, 3, 30 + k, 1, "full_bank");
        add_step(OP_PUSH, 3, 34, 0, "full_bank");
        add_step(OP_COMMIT, 3, 0, 0, "full_bank");
        add_step(OP_DRAIN, 0, 0, 0, "full_bank");
        add_step(OP_READ, 0, 'h4, 7, "full_bank");
        add_step(OP_OPEN, 4, 0, 0, "abandon");
        add_step(OP_PUSH, 4, 40, 1, "abandon");
        add_step(OP_PUSH, 4, 41, 1, "abandon");
        add_step(OP_ABANDON, 4, 0, 0, "abandon");
        add_step(OP_WAIT, 0, 4, 0, "abandon");
        add_step(OP_READ, 0, 'h0, 'h02, "abandon");
        add_step(OP_READ, 0, 'h8, 2, "abandon");
        add_step(OP_PUSH, 2, 23, 1, "release_stall");
        add_step(OP_STALL, 0, 1, 0, "release_stall");
        add_step(OP_COMMIT, 2, 0, 0, "release_stall");
        add_step(OP_DRAIN, 0, 0, 0, "release_stall");
        add_step(OP_STALL, 0, 0, 0, "release_stall");
        for (int k = 1; k < 5; k++) add_step(OP_OPEN, k, 0, 0, "flush");
        add_step(OP_PUSH, 1, 50, 1, "flush");
        add_step(OP_PUSH, 3, 51, 1, "flush");
        add_step(OP_PUSH, 3, 52, 1, "flush");
        add_step(OP_OPENRDY, 0, 0, 0, "flush");
        add_step(OP_WRITE, 0, 'hC, 1, "flush");
        add_step(OP_WAIT, 0, 6, 0, "flush");
        add_step(OP_OPENRDY, 0, 0, 1, "flush");
        add_step(OP_READ, 0, 'h0, 0, "flush");
        add_step(OP_READ, 0, 'h8, 5, "flush");
        add_step(OP_RDREL, 0, 'h4, 0, "released_clear");
        add_step(OP_WRITE, 0, 'h4, 0, "released_clear");
        add_step(OP_READ, 0, 'h4, 0, "released_clear");
        table_ready = 1'b1;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < op_q.size(); i++) begin
            int err_start;
            if (i == 0 || name_q[i] != name_q[i-1]) begin
                cur_name = name_q[i];
                err_start = errors;
                tests++;
            end
            run_step(i);
            if (i == op_q.size() - 1 || name_q[i+1] != name_q[i]) begin
                $display("test %s: %s", name_q[i], (errors == err_start) ? "ok" : "failed");
                if (errors != err_start) failed_tests++;
            end
        end
        $display("tests run %0d, tests failed %0d, check errors %0d", tests, failed_tests,
                 errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog scaled from the table length
    initial begin
        wait (table_ready);
        #(op_q.size() * 20 * 10);
        $display("Timeout: the run did not finish in the time allowed for the table");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: tb_freelist_chk.sv
// Bound checker for the free-list top level, covering release hold, write response hold and open_ready
`timescale 1ns/1ns

module tb_freelist_chk (
    input logic                clk,
    input logic                rst_n,
    input logic                release_valid,
    input logic                release_ready,
    input freelist_pkg::prf_t  release_prf,
    input logic                bvalid,
    input logic                bready,
    input logic                open_en,
    input logic                open_ready
);

    // Stalled release keeps its PRF
    property p_release_hold;
        @(posedge clk) disable iff (!rst_n)
            (release_valid && !release_ready) |=> $stable(release_prf);
    endproperty

    // Write response stays up until taken
    property p_bvalid_hold;
        @(posedge clk) disable iff (!rst_n)
            (bvalid && !bready) |=> bvalid;
    endproperty

    // Last free bank is taken only by an accepted open
    property p_open_ready;
        @(posedge clk) disable iff (!rst_n)
            $fell(open_ready) |-> $past(open_en && open_ready);
    endproperty

    a_release_hold: assert property (p_release_hold)
        else $error("release_prf changed while stalled");
    a_bvalid_hold: assert property (p_bvalid_hold)
        else $error("bvalid dropped before bready");
    a_open_ready: assert property (p_open_ready)
        else $error("open_ready fell without an accepted open");

endmodule

bind freelist_top tb_freelist_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .release_valid (release_valid),
    .release_ready (release_ready),
    .release_prf   (release_prf),
    .bvalid        (bvalid),
    .bready        (bready),
    .open_en       (open_en),
    .open_ready    (open_ready)
);

// File: freelist_top.sv
// Top level of the free-list stage: bank controller, four checkpoint banks and register block
`timescale 1ns/1ns

module freelist_top (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    open_en,
    input  freelist_pkg::fgr_t      open_fgr,
    output logic                    open_ready,
    input  logic                    push_en,
    input  freelist_pkg::fgr_t      push_fgr,
    input  freelist_pkg::prf_t      push_prf,
    output logic                    push_ready,
    input  logic                    commit_en,
    input  freelist_pkg::fgr_t      commit_fgr,
    input  logic                    abandon_en,
    input  freelist_pkg::fgr_t      abandon_fgr,
    output logic                    release_valid,
    output freelist_pkg::prf_t      release_prf,
    input  logic                    release_ready,

    input  freelist_pkg::csr_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  freelist_pkg::csr_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    logic [3:0] bank_valid, bank_abandoned, bank_full, bank_empty;
    logic [3:0] bank_tag_en, bank_tag_valid, bank_tag_abandoned;
    logic [3:0] bank_fgr_en, bank_wen, bank_ren;
    logic       flush_req, released_pulse, discarded_pulse;

    freelist_pkg::fgr_t bank_fgr  [freelist_pkg::NUM_BANKS];
    freelist_pkg::prf_t bank_head [freelist_pkg::NUM_BANKS];
    freelist_pkg::prf_t bank_prf;

    freelist_bank_ctrl u_ctrl (
        .clk (clk), .rst_n (rst_n),
        .open_en (open_en), .open_fgr (open_fgr), .open_ready (open_ready),
        .push_en (push_en), .push_fgr (push_fgr), .push_prf (push_prf),
        .push_ready (push_ready),
        .commit_en (commit_en), .commit_fgr (commit_fgr),
        .abandon_en (abandon_en), .abandon_fgr (abandon_fgr),
        .flush_req (flush_req),
        .release_valid (release_valid), .release_prf (release_prf),
        .release_ready (release_ready),
        .released_pulse (released_pulse), .discarded_pulse (discarded_pulse),
        .bank_valid (bank_valid), .bank_abandoned (bank_abandoned),
        .bank_fgr_0 (bank_fgr[0]), .bank_fgr_1 (bank_fgr[1]),
        .bank_fgr_2 (bank_fgr[2]), .bank_fgr_3 (bank_fgr[3]),
        .bank_full (bank_full), .bank_empty (bank_empty),
        .bank_head_0 (bank_head[0]), .bank_head_1 (bank_head[1]),
        .bank_head_2 (bank_head[2]), .bank_head_3 (bank_head[3]),
        .bank_tag_en (bank_tag_en), .bank_tag_valid (bank_tag_valid),
        .bank_tag_abandoned (bank_tag_abandoned), .bank_fgr_en (bank_fgr_en),
        .bank_wen (bank_wen), .bank_ren (bank_ren), .bank_prf (bank_prf)
    );

    for (genvar i = 0; i < freelist_pkg::NUM_BANKS; i++) begin : g_bank
        freelist_ckpt_bank u_bank (
            .clk (clk), .rst_n (rst_n),
            .tag_en (bank_tag_en[i]), .tag_valid (bank_tag_valid[i]),
            .tag_abandoned (bank_tag_abandoned[i]),
            // New group id comes straight from the open strobe
            .fgr_en (bank_fgr_en[i]), .fgr_in (open_fgr),
            .valid (bank_valid[i]), .abandoned (bank_abandoned[i]), .fgr_out (bank_fgr[i]),
            .fifo_wen (bank_wen[i]), .fifo_prf (bank_prf),
            .fifo_ren (bank_ren[i]), .fifo_prf_out (bank_head[i]),
            .fifo_full (bank_full[i]), .fifo_empty (bank_empty[i])
        );
    end

    freelist_csr u_csr (
        .clk (clk), .rst_n (rst_n),
        .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
        .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .araddr (araddr), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
        .bank_valid (bank_valid), .bank_abandoned (bank_abandoned),
        .released_pulse (released_pulse), .discarded_pulse (discarded_pulse),
        .flush_req (flush_req)
    );

endmodule

// File: freelist_csr.sv
// AXI4-Lite register block with bank status, release and discard counters and flush control
`timescale 1ns/1ns

module freelist_csr (
    input  logic                    clk,
    input  logic                    rst_n,

    input  freelist_pkg::csr_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [31:0]             wdata,
    input  logic [3:0]              wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output logic [1:0]              bresp,
    output logic                    bvalid,
    input  logic                    bready,

    input  freelist_pkg::csr_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [31:0]             rdata,
    output logic [1:0]              rresp,
    output logic                    rvalid,
    input  logic                    rready,

    input  logic [3:0]              bank_valid,
    input  logic [3:0]              bank_abandoned,
    input  logic                    released_pulse,
    input  logic                    discarded_pulse,
    output logic                    flush_req
);

    freelist_pkg::csr_wr_state_t wr_state;

    freelist_pkg::cnt_t released_cnt;
    freelist_pkg::cnt_t discarded_cnt;

    logic        wr_fire;
    logic        ar_fire;
    logic [31:0] rd_mux;

    // Write path takes AW and W in the same cycle
    assign awready = (wr_state == freelist_pkg::WR_IDLE);
    assign wready  = (wr_state == freelist_pkg::WR_IDLE);
    assign wr_fire = awvalid && wvalid && (wr_state == freelist_pkg::WR_IDLE);
    assign bvalid  = (wr_state == freelist_pkg::WR_RESP);
    assign bresp   = 2'b00;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= freelist_pkg::WR_IDLE;
        end else begin
            case (wr_state)
                freelist_pkg::WR_IDLE: if (wr_fire) wr_state <= freelist_pkg::WR_RESP;
                freelist_pkg::WR_RESP: if (bready) wr_state <= freelist_pkg::WR_IDLE;
                default: wr_state <= freelist_pkg::WR_IDLE;
            endcase
        end
    end

    // Single-cycle flush strobe, high while bvalid first shows
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_req <= 1'b0;
        end else begin
            flush_req <= wr_fire && (awaddr == freelist_pkg::ADDR_CTRL) && wstrb[0] && wdata[0];
        end
    end

    // Any write clears, and it wins over a pulse in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            released_cnt <= '0;
        end else if (wr_fire && (awaddr == freelist_pkg::ADDR_RELEASED)) begin
            released_cnt <= '0;
        end else if (released_pulse) begin
            released_cnt <= released_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            discarded_cnt <= '0;
        end else if (wr_fire && (awaddr == freelist_pkg::ADDR_DISCARDED)) begin
            discarded_cnt <= '0;
        end else if (discarded_pulse) begin
            discarded_cnt <= discarded_cnt + 1'b1;
        end
    end

    // Read path
    assign arready = !rvalid;
    assign ar_fire = arvalid && arready;
    assign rresp   = 2'b00;

    always_comb begin
        case (araddr)
            freelist_pkg::ADDR_STATUS:    rd_mux = {24'h0, bank_abandoned, bank_valid};
            freelist_pkg::ADDR_RELEASED:  rd_mux = {16'h0, released_cnt};
            freelist_pkg::ADDR_DISCARDED: rd_mux = {16'h0, discarded_cnt};
            default:                      rd_mux = 32'h0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (ar_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_mux;
        end
    end

endmodule

// File: freelist_bank_ctrl.sv
// Bank controller: opens banks, routes pushes, tracks commit and squash, drains to release
`timescale 1ns/1ns

module freelist_bank_ctrl (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               open_en,
    input  freelist_pkg::fgr_t open_fgr,
    output logic               open_ready,

    input  logic               push_en,
    input  freelist_pkg::fgr_t push_fgr,
    input  freelist_pkg::prf_t push_prf,
    output logic               push_ready,

    input  logic               commit_en,
    input  freelist_pkg::fgr_t commit_fgr,

    input  logic               abandon_en,
    input  freelist_pkg::fgr_t abandon_fgr,

    input  logic               flush_req,

    output logic               release_valid,
    output freelist_pkg::prf_t release_prf,
    input  logic               release_ready,

    output logic               released_pulse,
    output logic               discarded_pulse,

    input  logic [3:0]         bank_valid,
    input  logic [3:0]         bank_abandoned,
    input  freelist_pkg::fgr_t bank_fgr_0,
    input  freelist_pkg::fgr_t bank_fgr_1,
    input  freelist_pkg::fgr_t bank_fgr_2,
    input  freelist_pkg::fgr_t bank_fgr_3,
    input  logic [3:0]         bank_full,
    input  logic [3:0]         bank_empty,
    input  freelist_pkg::prf_t bank_head_0,
    input  freelist_pkg::prf_t bank_head_1,
    input  freelist_pkg::prf_t bank_head_2,
    input  freelist_pkg::prf_t bank_head_3,

    output logic [3:0]         bank_tag_en,
    output logic [3:0]         bank_tag_valid,
    output logic [3:0]         bank_tag_abandoned,
    output logic [3:0]         bank_fgr_en,
    output logic [3:0]         bank_wen,
    output logic [3:0]         bank_ren,
    output freelist_pkg::prf_t bank_prf
);

    freelist_pkg::fgr_t fgr_tag [freelist_pkg::NUM_BANKS];
    freelist_pkg::prf_t head    [freelist_pkg::NUM_BANKS];

    logic [3:0] drain_q;
    logic [3:0] live;
    logic [3:0] push_cand;
    logic [3:0] commit_hit;
    logic [3:0] abandon_hit;
    logic [3:0] retire;
    logic [3:0] rel_elig;
    logic [3:0] disc_elig;
    logic       open_dup;
    logic       open_go;
    logic       rel_fire;
    logic       disc_any;

    freelist_pkg::bank_idx_t open_idx;
    freelist_pkg::bank_idx_t push_idx;
    freelist_pkg::bank_idx_t rel_idx;
    freelist_pkg::bank_idx_t disc_idx;

    // Lowest set bit wins
    function automatic freelist_pkg::bank_idx_t lowest(input logic [3:0] vec);
        freelist_pkg::bank_idx_t idx;
        idx = '0;
        for (int i = freelist_pkg::NUM_BANKS - 1; i >= 0; i--) begin
            if (vec[i]) begin
                idx = freelist_pkg::bank_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign fgr_tag[0] = bank_fgr_0;
    assign fgr_tag[1] = bank_fgr_1;
    assign fgr_tag[2] = bank_fgr_2;
    assign fgr_tag[3] = bank_fgr_3;
    assign head[0]    = bank_head_0;
    assign head[1]    = bank_head_1;
    assign head[2]    = bank_head_2;
    assign head[3]    = bank_head_3;

    // Still collecting PRFs for its group
    assign live = bank_valid & ~bank_abandoned & ~drain_q;

    always_comb begin
        open_dup = 1'b0;
        for (int i = 0; i < freelist_pkg::NUM_BANKS; i++) begin
            push_cand[i]   = live[i] && (fgr_tag[i] == push_fgr) && !bank_full[i];
            commit_hit[i]  = commit_en && live[i] && (fgr_tag[i] == commit_fgr);
            abandon_hit[i] = bank_valid[i] && !bank_abandoned[i]
                          && (flush_req || (abandon_en && (fgr_tag[i] == abandon_fgr)));
            retire[i]      = bank_valid[i] && (drain_q[i] || bank_abandoned[i]) && bank_empty[i];
            rel_elig[i]    = bank_valid[i] && drain_q[i] && !bank_abandoned[i] && !bank_empty[i];
            disc_elig[i]   = bank_valid[i] && bank_abandoned[i] && !bank_empty[i];
            // A group may hold only one collecting bank
            open_dup       = open_dup || (live[i] && (fgr_tag[i] == open_fgr));
        end
    end

    assign open_idx = lowest(~bank_valid);
    assign push_idx = lowest(push_cand);
    assign rel_idx  = lowest(rel_elig);
    assign disc_idx = lowest(disc_elig);

    assign open_ready = ~&bank_valid;
    assign open_go    = open_en && open_ready && !open_dup;
    assign push_ready = |push_cand;

    // Tag updates
    assign bank_fgr_en        = open_go ? (4'b0001 << open_idx) : 4'b0000;
    assign bank_tag_en        = bank_fgr_en | retire | abandon_hit;
    assign bank_tag_valid     = ~retire;
    assign bank_tag_abandoned = abandon_hit & ~retire;

    assign bank_prf = push_prf;
    assign bank_wen = (push_en && push_ready) ? (4'b0001 << push_idx) : 4'b0000;

    // Release from the lowest draining bank
    assign release_valid = |rel_elig;
    assign release_prf   = head[rel_idx];
    assign rel_fire      = release_valid && release_ready;

    // One discard per cycle keeps the count exact
    assign disc_any = |disc_elig;

    assign bank_ren = (rel_fire ? (4'b0001 << rel_idx) : 4'b0000)
                    | (disc_any ? (4'b0001 << disc_idx) : 4'b0000);

    assign released_pulse  = rel_fire;
    assign discarded_pulse = disc_any;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drain_q <= '0;
        end else begin
            drain_q <= (drain_q & ~retire) | commit_hit;
        end
    end

endmodule

// File: freelist_ckpt_bank.sv
// One checkpoint bank: valid, abandoned and FGR tag registers next to a PRF FIFO
`timescale 1ns/1ns

module freelist_ckpt_bank (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               tag_en,
    input  logic               tag_valid,
    input  logic               tag_abandoned,

    input  logic               fgr_en,
    input  freelist_pkg::fgr_t fgr_in,

    output logic               valid,
    output logic               abandoned,
    output freelist_pkg::fgr_t fgr_out,

    input  logic               fifo_wen,
    input  freelist_pkg::prf_t fifo_prf,

    input  logic               fifo_ren,
    output freelist_pkg::prf_t fifo_prf_out,

    output logic               fifo_full,
    output logic               fifo_empty
);

    // Valid and abandoned load together
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid     <= 1'b0;
            abandoned <= 1'b0;
        end else if (tag_en) begin
            valid     <= tag_valid;
            abandoned <= tag_abandoned;
        end
    end

    // Group this bank belongs to
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fgr_out <= '0;
        end else if (fgr_en) begin
            fgr_out <= fgr_in;
        end
    end

    prf_fifo u_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (fifo_prf),
        .wen   (fifo_wen),
        .ren   (fifo_ren),
        .dout  (fifo_prf_out),
        .full  (fifo_full),
        .empty (fifo_empty)
    );

endmodule

// File: prf_fifo.sv
// Small circular FIFO of PRF numbers, one write and one read port, used inside each bank
`timescale 1ns/1ns

module prf_fifo (
    input  logic               clk,
    input  logic               rst_n,

    input  freelist_pkg::prf_t din,
    input  logic               wen,

    input  logic               ren,
    output freelist_pkg::prf_t dout,

    output logic               full,
    output logic               empty
);

    localparam int DEPTH = 1 << freelist_pkg::BANK_DEPTH_LOG2;

    freelist_pkg::prf_t mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [freelist_pkg::BANK_DEPTH_LOG2:0] wptr;
    logic [freelist_pkg::BANK_DEPTH_LOG2:0] rptr;

    logic do_write;
    logic do_read;

    assign empty = (wptr == rptr);
    assign full  = (wptr[freelist_pkg::BANK_DEPTH_LOG2] != rptr[freelist_pkg::BANK_DEPTH_LOG2])
                && (wptr[freelist_pkg::BANK_DEPTH_LOG2-1:0]
                    == rptr[freelist_pkg::BANK_DEPTH_LOG2-1:0]);

    assign do_write = wen && !full;
    assign do_read  = ren && !empty;

    // Head is always visible
    assign dout = mem[rptr[freelist_pkg::BANK_DEPTH_LOG2-1:0]];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wptr[freelist_pkg::BANK_DEPTH_LOG2-1:0]] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wptr <= '0;
        end else if (do_write) begin
            wptr <= wptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rptr <= '0;
        end else if (do_read) begin
            rptr <= rptr + 1'b1;
        end
    end

endmodule

// File: freelist_pkg.sv
// Shared types, sizes and register offsets for the checkpointed free-list stage
package freelist_pkg;

    // Physical register number, 64 PRFs
    typedef logic [5:0] prf_t;

    // Fine-grain group id
    typedef logic [2:0] fgr_t;

    // Index of one checkpoint bank
    typedef logic [1:0] bank_idx_t;

    // Event counter in the register block
    typedef logic [15:0] cnt_t;

    localparam int NUM_BANKS       = 4;
    localparam int BANK_DEPTH_LOG2 = 2;

    // Register block address
    localparam int ADDR_W = 4;
    typedef logic [ADDR_W-1:0] csr_addr_t;

    localparam csr_addr_t ADDR_STATUS    = 4'h0;
    localparam csr_addr_t ADDR_RELEASED  = 4'h4;
    localparam csr_addr_t ADDR_DISCARDED = 4'h8;
    localparam csr_addr_t ADDR_CTRL      = 4'hC;

    // Write path of the AXI4-Lite slave
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } csr_wr_state_t;

endpackage
